// ==== hdl/rv_pkg.sv ====
// rv_pkg: core widths, RV32 opcodes and function codes, special addresses, bus structs, FSM states
package rv_pkg;

    localparam int data_width    = 32;
    localparam int instr_width   = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs      = 32;

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // funct3 codes
    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // register-register codes, funct7 followed by funct3
    localparam logic [9:0] f_add  = {7'b0000000, 3'b000};
    localparam logic [9:0] f_sub  = {7'b0100000, 3'b000};
    localparam logic [9:0] f_sll  = {7'b0000000, 3'b001};
    localparam logic [9:0] f_sltu = {7'b0000000, 3'b011};
    localparam logic [9:0] f_xor  = {7'b0000000, 3'b100};
    localparam logic [9:0] f_srl  = {7'b0000000, 3'b101};
    localparam logic [9:0] f_or   = {7'b0000000, 3'b110};
    localparam logic [9:0] f_and  = {7'b0000000, 3'b111};
    localparam logic [9:0] f_mul  = {7'b0000001, 3'b000};

    // stores here never reach memory
    localparam logic [data_width-1:0] out_addr  = 32'd1000;
    localparam logic [data_width-1:0] halt_addr = 32'd1004;

    localparam logic [data_width-1:0] pc_step = 32'd4;

    typedef struct packed {
        logic [data_width-1:0] addr;
        logic [data_width-1:0] wr_data;
        logic                  rd;
        logic                  wr;
    } mem_req_t;

    typedef struct packed {
        logic [data_width-1:0] rd_data;
        logic                  ack;
    } mem_rsp_t;

    typedef struct packed {
        logic [6:0]               op;
        logic [2:0]               funct3;
        logic [9:0]               op_funct;
        logic [reg_sel_width-1:0] rd;
        logic [reg_sel_width-1:0] rs1;
        logic [reg_sel_width-1:0] rs2;
        logic [data_width-1:0]    i_imm;
        logic [data_width-1:0]    s_imm;
        logic [data_width-1:0]    b_imm;
        logic [data_width-1:0]    u_imm;
    } dec_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_halt
    } cpu_state_t;

endpackage

// ==== hdl/instr_decode.sv ====
// instr_decode: instruction field extraction and immediate generation
`timescale 1ns/1ps

module instr_decode (
    input  logic [rv_pkg::instr_width-1:0] instr,
    output rv_pkg::dec_t                   dec
);
    import rv_pkg::*;

    always_comb begin
        dec.op       = instr[6:0];
        dec.rd       = instr[11:7];
        dec.funct3   = instr[14:12];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.op_funct = {instr[31:25], instr[14:12]};

        // loads and ADDI
        dec.i_imm = {{(data_width - 12){instr[31]}}, instr[31:20]};

        // stores split the offset around rd
        dec.s_imm = {{(data_width - 12){instr[31]}}, instr[31:25], instr[11:7]};

        // branch offset in bytes, bit 0 always zero
        dec.b_imm = {
            {(data_width - 13){instr[31]}},
            instr[31],
            instr[7],
            instr[30:25],
            instr[11:8],
            1'b0
        };

        dec.u_imm = {instr[31:12], 12'b0};
    end

endmodule

// ==== hdl/reg_file.sv ====
// reg_file: 32 x 32-bit integer register file, two read ports and one write port
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [rv_pkg::reg_sel_width-1:0] rs1,
    input  logic [rv_pkg::reg_sel_width-1:0] rs2,
    output logic [rv_pkg::data_width-1:0]    rs1_data,
    output logic [rv_pkg::data_width-1:0]    rs2_data,
    input  logic                            wr_en,
    input  logic [rv_pkg::reg_sel_width-1:0] wr_sel,
    input  logic [rv_pkg::data_width-1:0]    wr_data
);
    import rv_pkg::*;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 never takes a write, so it stays zero
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// ==== hdl/alu.sv ====
// alu: register-register and ADDI results, BEQ/BNE condition
`timescale 1ns/1ps

module alu (
    input  rv_pkg::dec_t                 dec,
    input  logic [rv_pkg::data_width-1:0] a,
    input  logic [rv_pkg::data_width-1:0] b,
    output logic [rv_pkg::data_width-1:0] result,
    output logic                         taken
);
    import rv_pkg::*;

    always_comb begin
        result = '0;
        case (dec.op)
            op_op: begin
                case (dec.op_funct)
                    f_add:   result = a + b;
                    f_sub:   result = a - b;
                    f_and:   result = a & b;
                    f_or:    result = a | b;
                    f_xor:   result = a ^ b;
                    // shift amount is the low five bits only
                    f_sll:   result = a << b[4:0];
                    f_srl:   result = a >> b[4:0];
                    f_sltu:  result = (a < b) ? data_width'(1) : '0;
                    // low word of the product
                    f_mul:   result = a * b;
                    default: result = '0;
                endcase
            end
            op_opimm: begin
                if (dec.funct3 == f3_addi) begin
                    result = a + dec.i_imm;
                end
            end
            default: result = '0;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        if (dec.op == op_branch) begin
            case (dec.funct3)
                f3_beq:  taken = (a == b);
                f3_bne:  taken = (a != b);
                default: taken = 1'b0;
            endcase
        end
    end

endmodule

// ==== hdl/cpu_control.sv ====
// cpu_control: fetch/execute/memory FSM, program counter, memory requests, output port, halt
`timescale 1ns/1ps

module cpu_control (
    input  logic                            clk,
    input  logic                            rst,
    input  rv_pkg::dec_t                    dec,
    input  logic [rv_pkg::data_width-1:0]    rs1_data,
    input  logic [rv_pkg::data_width-1:0]    rs2_data,
    input  logic [rv_pkg::data_width-1:0]    alu_result,
    input  logic                            taken,
    output rv_pkg::mem_req_t                mem_req,
    input  rv_pkg::mem_rsp_t                mem_rsp,
    output logic                            wr_en,
    output logic [rv_pkg::reg_sel_width-1:0] wr_sel,
    output logic [rv_pkg::data_width-1:0]    wr_data,
    output logic [rv_pkg::data_width-1:0]    out_data,
    output logic                            out_valid,
    output logic                            halt
);
    import rv_pkg::*;

    cpu_state_t               state;
    cpu_state_t               state_next;
    logic [data_width-1:0]    pc;
    logic [data_width-1:0]    pc_next;
    logic [reg_sel_width-1:0] rd_q;
    logic [reg_sel_width-1:0] rd_next;
    logic                     boot;
    logic [data_width-1:0]    pc_seq;
    logic [data_width-1:0]    ls_addr;

    assign pc_seq = pc + pc_step;

    // effective address of the load or store being executed
    assign ls_addr = rs1_data + ((dec.op == op_store) ? dec.s_imm : dec.i_imm);

    // the port value is the store data, qualified by out_valid
    assign out_data = rs2_data;

    assign halt = (state == st_halt);

    always_comb begin
        state_next = state;
        pc_next    = pc;
        rd_next    = rd_q;
        mem_req    = '0;
        wr_en      = 1'b0;
        wr_sel     = dec.rd;
        wr_data    = alu_result;
        out_valid  = 1'b0;

        case (state)
            st_fetch: begin
                // first fetch goes out once the clock has run past reset
                if (!boot) begin
                    mem_req.rd   = 1'b1;
                    mem_req.addr = pc;
                    state_next   = st_exec;
                end
            end

            st_exec: begin
                if (mem_rsp.ack) begin
                    // dec reflects the instruction word in this cycle only
                    pc_next = pc_seq;
                    case (dec.op)
                        op_opimm, op_op: begin
                            wr_en = 1'b1;
                        end
                        op_lui: begin
                            wr_en   = 1'b1;
                            wr_data = dec.u_imm;
                        end
                        op_auipc: begin
                            wr_en   = 1'b1;
                            wr_data = dec.u_imm + pc;
                        end
                        op_branch: begin
                            if (taken) begin
                                pc_next = pc + dec.b_imm;
                            end
                        end
                        op_load: begin
                            mem_req.rd   = 1'b1;
                            mem_req.addr = ls_addr;
                            rd_next      = dec.rd;
                            pc_next      = pc;
                            state_next   = st_mem;
                        end
                        op_store: begin
                            if (ls_addr == out_addr) begin
                                out_valid = 1'b1;
                            end else if (ls_addr == halt_addr) begin
                                pc_next    = pc;
                                state_next = st_halt;
                            end else begin
                                mem_req.wr      = 1'b1;
                                mem_req.addr    = ls_addr;
                                mem_req.wr_data = rs2_data;
                                // x0 as target makes the completion write a no-op
                                rd_next         = '0;
                                pc_next         = pc;
                                state_next      = st_mem;
                            end
                        end
                        default: begin
                            // unknown opcode
                            pc_next    = pc;
                            state_next = st_halt;
                        end
                    endcase

                    // next fetch in the same cycle when nothing else is pending
                    if (state_next == st_exec) begin
                        mem_req.rd   = 1'b1;
                        mem_req.addr = pc_next;
                    end
                end
            end

            st_mem: begin
                if (mem_rsp.ack) begin
                    wr_en        = 1'b1;
                    wr_sel       = rd_q;
                    wr_data      = mem_rsp.rd_data;
                    pc_next      = pc_seq;
                    mem_req.rd   = 1'b1;
                    mem_req.addr = pc_seq;
                    state_next   = st_exec;
                end
            end

            default: begin
                // st_halt, only reset leaves it
                state_next = st_halt;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= '0;
            rd_q  <= '0;
            boot  <= 1'b1;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            rd_q  <= rd_next;
            boot  <= 1'b0;
        end
    end

endmodule

// ==== hdl/cpu_top.sv ====
// cpu_top: multi-cycle RV32 core built from decoder, register file, ALU and control FSM
`timescale 1ns/1ps

module cpu_top (
    input  logic                         clk,
    input  logic                         rst,
    output rv_pkg::mem_req_t             mem_req,
    input  rv_pkg::mem_rsp_t             mem_rsp,
    output logic [rv_pkg::data_width-1:0] out_data,
    output logic                         out_valid,
    output logic                         halt
);
    import rv_pkg::*;

    dec_t                     dec;
    logic [data_width-1:0]    rs1_data;
    logic [data_width-1:0]    rs2_data;
    logic [data_width-1:0]    alu_result;
    logic                     taken;
    logic                     wr_en;
    logic [reg_sel_width-1:0] wr_sel;
    logic [data_width-1:0]    wr_data;

    // instruction word is taken straight off the read data bus
    instr_decode i_instr_decode (
        .instr (mem_rsp.rd_data),
        .dec   (dec)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    alu i_alu (
        .dec    (dec),
        .a      (rs1_data),
        .b      (rs2_data),
        .result (alu_result),
        .taken  (taken)
    );

    cpu_control i_cpu_control (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .taken      (taken),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .halt       (halt)
    );

endmodule

// ==== testbench/mem_model.sv ====
// mem_model: behavioral 1024-word memory with request/acknowledge handshake and random ack delay
`timescale 1ns/1ps

module mem_model (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::mem_req_t mem_req,
    output rv_pkg::mem_rsp_t mem_rsp
);
    import rv_pkg::*;

    logic [data_width-1:0] mem [1024];

    mem_req_t req_q;
    mem_rsp_t next_rsp;
    logic     pending;
    int       count;

    initial begin
        mem_rsp = '0;
        pending = 1'b0;
        count   = 0;
    end

    always @(posedge clk) begin
        next_rsp = '0;
        if (rst) begin
            pending = 1'b0;
        end else begin
            if (pending) begin
                count = count - 1;
                if (count == 0) begin
                    pending      = 1'b0;
                    next_rsp.ack = 1'b1;
                    // word address from the byte address
                    if (req_q.wr) begin
                        mem[req_q.addr[11:2]] = req_q.wr_data;
                    end else begin
                        next_rsp.rd_data = mem[req_q.addr[11:2]];
                    end
                end
            end
            if (mem_req.rd || mem_req.wr) begin
                pending = 1'b1;
                req_q   = mem_req;
                count   = int'($urandom_range(4, 1));
            end
        end
        // response changes shortly after the edge
        #1;
        mem_rsp = next_rsp;
    end

endmodule

// ==== testbench/cpu_top_chk.sv ====
// cpu_top_chk: concurrent assertions on the memory handshake and halt, bound into cpu_top
`timescale 1ns/1ps

module cpu_top_chk (
    input logic             clk,
    input logic             rst,
    input rv_pkg::mem_req_t mem_req,
    input rv_pkg::mem_rsp_t mem_rsp,
    input logic             halt
);
    logic req_any;
    logic outstanding;

    assign req_any = mem_req.rd || mem_req.wr;

    // one request in flight, cleared by ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (req_any) begin
            outstanding <= 1'b1;
        end else if (mem_rsp.ack) begin
            outstanding <= 1'b0;
        end
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(mem_req.rd && mem_req.wr))
        else $error("read and write requested together");

    no_req_before_ack: assert property (@(posedge clk) disable iff (rst)
        (outstanding && !mem_rsp.ack) |-> !req_any)
        else $error("request issued before ack");

    halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else $error("halt dropped without reset");

    halt_quiet: assert property (@(posedge clk) disable iff (rst) halt |-> !req_any)
        else $error("request issued while halted");

endmodule

bind cpu_top cpu_top_chk i_cpu_top_chk (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .halt    (halt)
);

// ==== testbench/tb_cpu_top.sv ====
// clock, reset, program encoder and loader, directed tests, value check
`timescale 1ns/1ps

module tb_cpu_top;
    import rv_pkg::*;

    logic                  clk;
    logic                  rst;
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;
    logic [data_width-1:0] out_data;
    logic                  out_valid;
    logic                  halt;

    logic [31:0] prog [$];
    logic [31:0] outs [$];
    logic [31:0] expect_q [$];

    cpu_top i_cpu_top (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halt      (halt)
    );

    mem_model i_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "mismatch");
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [9:0] fn, input int rd, input int rs1,
                                          input int rs2);
        return {fn[9:3], 5'(rs2), 5'(rs1), fn[2:0], 5'(rd), op_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input int rd, input int rs1,
                                          input int imm);
        logic [11:0] imm12;
        imm12 = 12'(imm);
        // loads use funct3 010, ADDI uses 000
        return {imm12, 5'(rs1), (op == op_load) ? 3'b010 : f3_addi, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input int rs1, input int rs2, input int imm);
        logic [11:0] imm12;
        imm12 = 12'(imm);
        return {imm12[11:5], 5'(rs2), 5'(rs1), 3'b010, imm12[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int imm);
        logic [12:0] imm13;
        imm13 = 13'(imm);
        return {imm13[12], imm13[10:5], 5'(rs2), 5'(rs1), f3, imm13[4:1], imm13[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input int rd, input int imm);
        return {20'(imm), 5'(rd), op};
    endfunction

    task automatic emit_out(input int rs);
        prog.push_back(enc_s(0, rs, int'(out_addr)));
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            // unwritten words hold an unknown opcode tagged with their index
            i_mem.mem[i] = {22'(i), 10'h3FF};
        end
        foreach (prog[i]) begin
            i_mem.mem[i] = prog[i];
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    // collect out_data strobes until halt
    task automatic collect_outputs();
        int cycles;
        cycles = 0;
        outs.delete();
        while (!halt) begin
            @(negedge clk);
            if (out_valid) begin
                outs.push_back(out_data);
            end
            cycles++;
            if (cycles > 3000) begin
                fail_run("timeout waiting for halt");
            end
        end
    endtask

    task automatic run_and_compare(input string name);
        load_program();
        reset_dut();
        collect_outputs();
        check_value({name, " count"}, 32'(expect_q.size()), 32'(outs.size()));
        foreach (expect_q[i]) begin
            check_value(name, expect_q[i], outs[i]);
        end
    endtask

    task automatic check_quiet_after_halt(input string name);
        repeat (20) begin
            @(negedge clk);
            if (out_valid || mem_req.rd || mem_req.wr || !halt) begin
                fail_run({name, ": activity after halt"});
            end
        end
    endtask

    task automatic test_reset();
        int cycles;
        prog.delete();
        emit_out(0);
        prog.push_back(enc_s(0, 0, int'(halt_addr)));
        load_program();
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("reset_idle", 32'd0, 32'({halt, out_valid, mem_req.rd, mem_req.wr}));
            @(posedge clk);
        end
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("after_reset", 32'd0, 32'({halt, out_valid}));
        cycles = 0;
        while (!(mem_req.rd || mem_req.wr)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_run("no first fetch after reset");
            end
        end
        check_value("first_fetch_rd", 32'd1, 32'(mem_req.rd));
        check_value("first_fetch_addr", 32'd0, mem_req.addr);
        collect_outputs();
        check_value("reset_prog_count", 32'd1, 32'(outs.size()));
    endtask

    task automatic test_arith();
        logic [9:0]  fns [9];
        logic [31:0] a;
        logic [31:0] b;
        fns = '{f_add, f_sub, f_and, f_or, f_xor, f_sll, f_srl, f_sltu, f_mul};
        a = 32'h1234_5678;
        b = 32'hFFFF_FFF3;
        prog.delete();
        expect_q.delete();
        prog.push_back(enc_u(op_lui, 1, 'h12345));
        prog.push_back(enc_i(op_opimm, 1, 1, 'h678));
        prog.push_back(enc_i(op_opimm, 2, 0, -13));
        foreach (fns[i]) begin
            prog.push_back(enc_r(fns[i], 10 + i, 1, 2));
            emit_out(10 + i);
        end
        // operands swapped so the shifted word has its top bit set
        prog.push_back(enc_r(f_srl, 19, 2, 1));
        emit_out(19);
        prog.push_back(enc_s(0, 0, int'(halt_addr)));
        expect_q = '{a + b, a - b, a & b, a | b, a ^ b, a << b[4:0], a >> b[4:0],
                     (a < b) ? 32'd1 : 32'd0, a * b, b >> a[4:0]};
        run_and_compare("arith");
    endtask

    task automatic test_memory();
        prog.delete();
        prog.push_back(enc_i(op_opimm, 1, 0, 'h111));
        prog.push_back(enc_i(op_opimm, 2, 0, -5));
        prog.push_back(enc_u(op_lui, 3, 'hABCDE));
        prog.push_back(enc_i(op_opimm, 3, 3, 'h123));
        prog.push_back(enc_s(0, 1, 512));
        prog.push_back(enc_s(0, 2, 516));
        prog.push_back(enc_s(0, 3, 520));
        prog.push_back(enc_i(op_load, 4, 0, 512));
        prog.push_back(enc_i(op_load, 5, 0, 516));
        prog.push_back(enc_i(op_load, 6, 0, 520));
        emit_out(4);
        emit_out(5);
        emit_out(6);
        prog.push_back(enc_s(0, 0, int'(halt_addr)));
        expect_q = '{32'h0000_0111, 32'hFFFF_FFFB, 32'hABCD_E123};
        run_and_compare("memory");
        check_value("mem_word_128", 32'h0000_0111, i_mem.mem[128]);
        check_value("mem_word_129", 32'hFFFF_FFFB, i_mem.mem[129]);
        check_value("mem_word_130", 32'hABCD_E123, i_mem.mem[130]);
    endtask

    task automatic test_branch();
        int auipc_pc;
        prog.delete();
        prog.push_back(enc_i(op_opimm, 1, 0, 5));
        prog.push_back(enc_i(op_opimm, 2, 0, 5));
        prog.push_back(enc_i(op_opimm, 3, 0, 7));
        // each branch skips over a two-word marker when taken
        prog.push_back(enc_b(f3_beq, 1, 2, 12));
        prog.push_back(enc_i(op_opimm, 10, 0, 'hA1));
        emit_out(10);
        prog.push_back(enc_b(f3_beq, 1, 3, 12));
        prog.push_back(enc_i(op_opimm, 10, 0, 'hB2));
        emit_out(10);
        prog.push_back(enc_b(f3_bne, 1, 3, 12));
        prog.push_back(enc_i(op_opimm, 10, 0, 'hC3));
        emit_out(10);
        prog.push_back(enc_b(f3_bne, 1, 2, 12));
        prog.push_back(enc_i(op_opimm, 10, 0, 'hD4));
        emit_out(10);
        auipc_pc = prog.size() * 4;
        prog.push_back(enc_u(op_auipc, 11, 2));
        emit_out(11);
        prog.push_back(enc_s(0, 0, int'(halt_addr)));
        expect_q = '{32'h0000_00B2, 32'h0000_00D4, 32'(auipc_pc) + 32'h0000_2000};
        run_and_compare("branch");
    endtask

    task automatic test_x0();
        prog.delete();
        prog.push_back(enc_i(op_opimm, 0, 0, 123));
        emit_out(0);
        prog.push_back(enc_s(0, 0, int'(halt_addr)));
        expect_q = '{32'd0};
        run_and_compare("x0");
    endtask

    task automatic test_halt_store();
        prog.delete();
        prog.push_back(enc_i(op_opimm, 1, 0, 42));
        emit_out(1);
        prog.push_back(enc_s(0, 0, int'(halt_addr)));
        emit_out(1);
        expect_q = '{32'd42};
        run_and_compare("halt_store");
        check_quiet_after_halt("halt_store");
    endtask

    task automatic test_halt_opcode();
        prog.delete();
        prog.push_back(enc_i(op_opimm, 1, 0, 77));
        emit_out(1);
        prog.push_back(32'hFFFF_FFFF);
        emit_out(1);
        expect_q = '{32'd77};
        run_and_compare("halt_opcode");
        check_quiet_after_halt("halt_opcode");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        void'($urandom(28));
        test_reset();
        test_arith();
        test_memory();
        test_branch();
        test_x0();
        test_halt_store();
        test_halt_opcode();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/rv_pkg.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
testbench/mem_model.sv
testbench/cpu_top_chk.sv
testbench/tb_cpu_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_cpu_top -Mdir obj_dir -f vlog.f
	./obj_dir/Vtb_cpu_top

clean:
	rm -rf obj_dir
